//--- rcc_pkg.sv
// shared defaults for the RCC reset block
// kernel domain index and reset-cause flag positions live here
// RCC_RST_PULSE must stay above RCC_STAGE_NUM

package rcc_pkg;

  // ==========================================================
  // default parameter values
  // ==========================================================
  localparam int RCC_STAGE_NUM   = 2;
  localparam int RCC_NUM_KER     = 8;
  localparam int RCC_RST_PULSE   = 16;
  localparam int RCC_CSS_TIMEOUT = 32;
  localparam int RCC_NUM_FLAGS   = 4;

  // ==========================================================
  // kernel clock domain index
  // ==========================================================
  typedef enum logic [2:0] {
    KER_PLL1_P = 3'd0,
    KER_PLL1_Q = 3'd1,
    KER_PLL2_P = 3'd2,
    KER_HSE    = 3'd3,  // also the oscillator watched by the CSS
    KER_HSI    = 3'd4,
    KER_CSI    = 3'd5,
    KER_LSE    = 3'd6,
    KER_PER    = 3'd7
  } ker_dom_e;

  // bit positions in rst_flags
  typedef enum logic [1:0] {
    FLAG_POR_PIN = 2'd0,
    FLAG_SW      = 2'd1,
    FLAG_WDG     = 2'd2,
    FLAG_CSS     = 2'd3
  } rst_flag_e;

endpackage

//--- rcc_reset_sync.sv
// reset synchronizer with asynchronous assert and synchronous release
// release appears on the STAGE_NUM-th clk edge after src_rst_n rises
// in test mode the source reset is passed straight through

`timescale 1ns/1ps

module rcc_reset_sync
  import rcc_pkg::*;
#(
  parameter int STAGE_NUM = RCC_STAGE_NUM
) (
  input  logic clk,
  input  logic src_rst_n,
  input  logic testmode,
  output logic gen_rst_n
);

  logic [STAGE_NUM-1:0] sync_q;

  // shift chain cleared by the source reset
  always_ff @(posedge clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= 1'b1;
      for (int i = 1; i < STAGE_NUM; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // test bypass keeps the reset directly controllable
  assign gen_rst_n = testmode ? src_rst_n : sync_q[STAGE_NUM-1];

  // ==========================================================
  // checks
  // ==========================================================

  // a low source must always be visible at the output
  a_src_low_gen_low : assert property (
    @(posedge clk) !src_rst_n |-> !gen_rst_n
  ) else $error("gen_rst_n high while src_rst_n low");

endmodule

//--- rcc_sys_rst_ctrl.sv
// system reset generation in the sys_clk domain
// rst_n releases through a synchronizer, the stretch counter makes up
// for its latency, so RST_PULSE must be larger than RCC_STAGE_NUM
// flags are sticky until rmvf or the next rst_n

`timescale 1ns/1ps

module rcc_sys_rst_ctrl
  import rcc_pkg::*;
#(
  parameter int RST_PULSE = RCC_RST_PULSE
) (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  logic                     sw_rst_req,
  input  logic                     wdg_rst_req,
  input  logic                     css_event,
  input  logic                     rmvf,
  output logic                     sys_rst_n,
  output logic [RCC_NUM_FLAGS-1:0] rst_flags
);

  localparam int SYNC_STAGES = RCC_STAGE_NUM;
  localparam int POR_LOAD    = RST_PULSE - SYNC_STAGES;
  localparam int CNT_W       = $clog2(RST_PULSE + 1);

  logic                     por_sync_n;
  logic                     rst_req;
  logic [CNT_W-1:0]         rst_cnt;
  logic                     css_event_q;
  logic [RCC_NUM_FLAGS-1:0] flag_set;

  // power-on/pin reset, released in sys_clk
  rcc_reset_sync #(
    .STAGE_NUM(SYNC_STAGES)
  ) u_por_sync (
    .clk      (sys_clk),
    .src_rst_n(rst_n),
    .testmode (1'b0),
    .gen_rst_n(por_sync_n)
  );

  assign rst_req = sw_rst_req | wdg_rst_req;

  // ==========================================================
  // stretch counter
  // ==========================================================

  // por load is short by the synchronizer latency
  always_ff @(posedge sys_clk or negedge por_sync_n) begin
    if (!por_sync_n) begin
      rst_cnt   <= CNT_W'(POR_LOAD);
      sys_rst_n <= 1'b0;
    end else begin
      if (rst_req) begin
        rst_cnt <= CNT_W'(RST_PULSE);
      end else if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      // release on the edge that takes the count to zero
      sys_rst_n <= !rst_req && (rst_cnt <= CNT_W'(1));
    end
  end

  // ==========================================================
  // reset-cause flags
  // ==========================================================

  always_comb begin
    flag_set           = '0;
    flag_set[FLAG_SW]  = sw_rst_req;
    flag_set[FLAG_WDG] = wdg_rst_req;
    flag_set[FLAG_CSS] = css_event & ~css_event_q;
  end

  always_ff @(posedge sys_clk or negedge por_sync_n) begin
    if (!por_sync_n) begin
      css_event_q            <= 1'b0;
      rst_flags              <= '0;
      rst_flags[FLAG_POR_PIN] <= 1'b1;
    end else begin
      css_event_q <= css_event;
      // a cause in the same cycle as rmvf still lands
      rst_flags   <= (rmvf ? '0 : rst_flags) | flag_set;
    end
  end

  // counter must be done before the system comes out of reset
  a_no_release_mid_count : assert property (
    @(posedge sys_clk) disable iff (!por_sync_n)
    $rose(sys_rst_n) |-> (rst_cnt == '0)
  ) else $error("sys_rst_n released with rst_cnt=%0h", rst_cnt);

endmodule

//--- rcc_hse_css.sv
// clock security monitor for the external oscillator
// a stopped oscillator is reported within CSS_TIMEOUT+4 sys_clk cycles
// the oscillator must toggle faster than CSS_TIMEOUT sys_clk cycles

`timescale 1ns/1ps

module rcc_hse_css
  import rcc_pkg::*;
#(
  parameter int CSS_TIMEOUT = RCC_CSS_TIMEOUT
) (
  input  logic sys_clk,
  input  logic rst_n,
  input  logic hse_origin_clk,
  input  logic css_en,
  input  logic css_clr,
  output logic hsecss_fail
);

  localparam int CNT_W = $clog2(CSS_TIMEOUT + 1);

  logic             hse_tgl;
  logic             tgl_meta;
  logic             tgl_sync;
  logic             tgl_last;
  logic             tgl_change;
  logic             mon_en;
  logic [CNT_W-1:0] wd_cnt;

  // ==========================================================
  // oscillator domain
  // ==========================================================

  // flips on every oscillator edge
  always_ff @(posedge hse_origin_clk or negedge rst_n) begin
    if (!rst_n) begin
      hse_tgl <= 1'b0;
    end else begin
      hse_tgl <= ~hse_tgl;
    end
  end

  // ==========================================================
  // sys_clk domain
  // ==========================================================

  // two-flop sync, plus one more flop for change detection
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      tgl_meta <= 1'b0;
      tgl_sync <= 1'b0;
      tgl_last <= 1'b0;
    end else begin
      tgl_meta <= hse_tgl;
      tgl_sync <= tgl_meta;
      tgl_last <= tgl_sync;
    end
  end

  assign tgl_change = tgl_sync ^ tgl_last;

  // watchdog, restarted by oscillator activity, enable or clear
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wd_cnt <= CNT_W'(CSS_TIMEOUT - 1);
    end else if (tgl_change || css_en || css_clr) begin
      wd_cnt <= CNT_W'(CSS_TIMEOUT - 1);
    end else if (wd_cnt != '0) begin
      wd_cnt <= wd_cnt - 1'b1;
    end
  end

  // monitoring stays on until reset, fail is sticky until clr
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      mon_en      <= 1'b0;
      hsecss_fail <= 1'b0;
    end else begin
      if (css_en) begin
        mon_en <= 1'b1;
      end
      if (css_clr) begin
        hsecss_fail <= 1'b0;
      end else if (mon_en && wd_cnt == '0) begin
        hsecss_fail <= 1'b1;
      end
    end
  end

  a_no_fail_when_off : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    $rose(hsecss_fail) |-> $past(mon_en)
  ) else $error("hsecss_fail rose with monitoring off");

endmodule

//--- rcc_port_rst_sync.sv
// hands sys_rst_n to every kernel clock domain
// and turns the CSS failure into a reset released in sys_clk
// in test mode every output reset follows test_rst_n

`timescale 1ns/1ps

module rcc_port_rst_sync
  import rcc_pkg::*;
#(
  parameter int STAGE_NUM = RCC_STAGE_NUM,
  parameter int NUM_KER   = RCC_NUM_KER
) (
  input  logic               sys_clk,
  input  logic [NUM_KER-1:0] ker_clk,
  input  logic               sys_rst_n,
  input  logic               hsecss_fail,
  input  logic               test_rst_n,
  input  logic               testmode,
  output logic [NUM_KER-1:0] ker_rst_n,
  output logic               sync_hsecss_fail_rst
);

  logic ker_src_rst_n;
  logic raw_hsecss_fail_n;
  logic hsecss_fail_n;
  logic sync_hsecss_fail_rst_n;

  // test mux for the kernel source
  assign ker_src_rst_n = testmode ? test_rst_n : sys_rst_n;

  // ==========================================================
  // sync with sys_clk
  // ==========================================================

  assign raw_hsecss_fail_n = ~hsecss_fail;
  assign hsecss_fail_n     = testmode ? test_rst_n : raw_hsecss_fail_n;

  rcc_reset_sync #(
    .STAGE_NUM(STAGE_NUM)
  ) u_hsecss_fail_n_sync (
    .clk      (sys_clk),
    .src_rst_n(hsecss_fail_n),
    .testmode (testmode),
    .gen_rst_n(sync_hsecss_fail_rst_n)
  );

  // active high toward the consumers
  assign sync_hsecss_fail_rst = ~sync_hsecss_fail_rst_n;

  // ==========================================================
  // sync with kernel clocks
  // ==========================================================

  for (genvar i = 0; i < NUM_KER; i++) begin : g_ker
    rcc_reset_sync #(
      .STAGE_NUM(STAGE_NUM)
    ) u_ker_rst_sync (
      .clk      (ker_clk[i]),
      .src_rst_n(ker_src_rst_n),
      .testmode (testmode),
      .gen_rst_n(ker_rst_n[i])
    );
  end

endmodule

//--- rcc_rst_top.sv
// reset part of the RCC: controller, clock security monitor
// and kernel domain reset distribution
// ker_clk[KER_HSE] doubles as the watched oscillator clock
// NUM_KER must cover every entry of ker_dom_e

`timescale 1ns/1ps

module rcc_rst_top
  import rcc_pkg::*;
#(
  parameter int STAGE_NUM   = RCC_STAGE_NUM,
  parameter int NUM_KER     = RCC_NUM_KER,
  parameter int RST_PULSE   = RCC_RST_PULSE,
  parameter int CSS_TIMEOUT = RCC_CSS_TIMEOUT
) (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  logic [NUM_KER-1:0]       ker_clk,
  input  logic                     sw_rst_req,
  input  logic                     wdg_rst_req,
  input  logic                     rmvf,
  input  logic                     css_en,
  input  logic                     css_clr,
  input  logic                     testmode,
  input  logic                     test_rst_n,
  output logic                     sys_rst_n,
  output logic [NUM_KER-1:0]       ker_rst_n,
  output logic                     sync_hsecss_fail_rst,
  output logic                     hsecss_fail,
  output logic [RCC_NUM_FLAGS-1:0] rst_flags
);

  logic hse_origin_clk;

  assign hse_origin_clk = ker_clk[KER_HSE];

  // ==========================================================
  // system reset and cause flags
  // ==========================================================
  rcc_sys_rst_ctrl #(
    .RST_PULSE(RST_PULSE)
  ) u_sys_rst_ctrl (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .sw_rst_req (sw_rst_req),
    .wdg_rst_req(wdg_rst_req),
    .css_event  (hsecss_fail),
    .rmvf       (rmvf),
    .sys_rst_n  (sys_rst_n),
    .rst_flags  (rst_flags)
  );

  // oscillator watch
  rcc_hse_css #(
    .CSS_TIMEOUT(CSS_TIMEOUT)
  ) u_hse_css (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .hse_origin_clk(hse_origin_clk),
    .css_en        (css_en),
    .css_clr       (css_clr),
    .hsecss_fail   (hsecss_fail)
  );

  // ==========================================================
  // per-domain reset release
  // ==========================================================
  rcc_port_rst_sync #(
    .STAGE_NUM(STAGE_NUM),
    .NUM_KER  (NUM_KER)
  ) u_port_rst_sync (
    .sys_clk             (sys_clk),
    .ker_clk             (ker_clk),
    .sys_rst_n           (sys_rst_n),
    .hsecss_fail         (hsecss_fail),
    .test_rst_n          (test_rst_n),
    .testmode            (testmode),
    .ker_rst_n           (ker_rst_n),
    .sync_hsecss_fail_rst(sync_hsecss_fail_rst)
  );

endmodule

//--- rcc_rst_tb.sv
// testbench for rcc_rst_top with default parameters
// concurrent assertions compare the DUT with small reference models
// each kernel clock has its own half period and drifts against sys_clk

`timescale 1ns/1ps

module rcc_rst_tb
  import rcc_pkg::*;
();

  localparam int STAGE_NUM   = RCC_STAGE_NUM;
  localparam int NUM_KER     = RCC_NUM_KER;
  localparam int RST_PULSE   = RCC_RST_PULSE;
  localparam int CSS_TIMEOUT = RCC_CSS_TIMEOUT;

  // strobe select
  localparam int STB_SW      = 0;
  localparam int STB_WDG     = 1;
  localparam int STB_RMVF    = 2;
  localparam int STB_CSS_EN  = 3;
  localparam int STB_CSS_CLR = 4;

  // outputs a wait can watch
  localparam int W_SYS_RST   = 0;
  localparam int W_FAIL      = 1;
  localparam int W_SYNC_FAIL = 2;

  logic                     sys_clk;
  logic                     rst_n;
  logic                     sw_rst_req;
  logic                     wdg_rst_req;
  logic                     rmvf;
  logic                     css_en;
  logic                     css_clr;
  logic                     testmode;
  logic                     test_rst_n;
  wire  [NUM_KER-1:0]       ker_clk;
  wire                      sys_rst_n;
  wire  [NUM_KER-1:0]       ker_rst_n;
  wire                      sync_hsecss_fail_rst;
  wire                      hsecss_fail;
  wire  [RCC_NUM_FLAGS-1:0] rst_flags;

  logic hse_stop;
  logic chk_en;
  int   err_cnt;
  int   tmo_cnt;

  // reference model state
  int                       model_cnt    = RST_PULSE;
  logic [RCC_NUM_FLAGS-1:0] model_flags  = 4'b0001;
  logic [RCC_NUM_FLAGS-1:0] flag_hit;
  logic                     fail_q       = 1'b0;
  logic                     css_on       = 1'b0;
  int                       fail_low_cnt = 0;
  logic                     hse_seen_tgl = 1'b0;
  logic                     hse_seen_q   = 1'b0;
  int                       hse_idle     = 0;

  initial sys_clk = 1'b0;

  always #5 begin
    sys_clk = ~sys_clk;
  end

  rcc_rst_top u_dut (
    .sys_clk             (sys_clk),
    .rst_n               (rst_n),
    .ker_clk             (ker_clk),
    .sw_rst_req          (sw_rst_req),
    .wdg_rst_req         (wdg_rst_req),
    .rmvf                (rmvf),
    .css_en              (css_en),
    .css_clr             (css_clr),
    .testmode            (testmode),
    .test_rst_n          (test_rst_n),
    .sys_rst_n           (sys_rst_n),
    .ker_rst_n           (ker_rst_n),
    .sync_hsecss_fail_rst(sync_hsecss_fail_rst),
    .hsecss_fail         (hsecss_fail),
    .rst_flags           (rst_flags)
  );

  // ==========================================================
  // reference models
  // ==========================================================

  // sys_rst_n high once RST_PULSE edges passed with no cause
  always @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      model_cnt <= RST_PULSE;
    end else if (sw_rst_req || wdg_rst_req) begin
      model_cnt <= RST_PULSE;
    end else if (model_cnt != 0) begin
      model_cnt <= model_cnt - 1;
    end
  end

  // bit order css, wdg, sw, por_pin
  assign flag_hit = {hsecss_fail & ~fail_q, wdg_rst_req, sw_rst_req, 1'b0};

  always @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      model_flags <= 4'b0001;
      fail_q      <= 1'b0;
      css_on      <= 1'b0;
    end else begin
      model_flags <= (rmvf ? 4'b0000 : model_flags) | flag_hit;
      fail_q      <= hsecss_fail;
      if (css_en) begin
        css_on <= 1'b1;
      end
    end
  end

  // sys_clk edges since the failure went away
  always @(posedge sys_clk or posedge hsecss_fail) begin
    if (hsecss_fail) begin
      fail_low_cnt <= 0;
    end else if (fail_low_cnt < STAGE_NUM) begin
      fail_low_cnt <= fail_low_cnt + 1;
    end
  end

  // sys_clk edges since the last oscillator edge
  always @(posedge ker_clk[KER_HSE]) begin
    hse_seen_tgl <= ~hse_seen_tgl;
  end

  always @(posedge sys_clk) begin
    hse_seen_q <= hse_seen_tgl;
    if (hse_seen_tgl != hse_seen_q) begin
      hse_idle <= 1;
    end else if (hse_idle < 1000) begin
      hse_idle <= hse_idle + 1;
    end
  end

  // ==========================================================
  // kernel clocks and per-domain release check
  // ==========================================================
  for (genvar i = 0; i < NUM_KER; i++) begin : g_ker
    localparam real HALF_NS = 3.1 + 0.6 * i;

    logic kclk    = 1'b0;
    int   rel_cnt = 0;

    // only the oscillator domain can be stopped
    always #(HALF_NS) begin
      if (!(i == int'(KER_HSE) && hse_stop)) begin
        kclk = ~kclk;
      end
    end

    assign ker_clk[i] = kclk;

    always @(posedge kclk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
        rel_cnt <= 0;
      end else if (rel_cnt < STAGE_NUM) begin
        rel_cnt <= rel_cnt + 1;
      end
    end

    a_ker_release : assert property (
      @(posedge kclk) disable iff (!chk_en || testmode)
      ker_rst_n[i] == (rel_cnt >= STAGE_NUM)
    ) else begin
      err_cnt++;
      $display("** Error: ker_rst_n[%0d] = %h, expected %h", i,
               $sampled(ker_rst_n[i]), $sampled(rel_cnt >= STAGE_NUM));
    end
  end

  // ==========================================================
  // checks in sys_clk
  // ==========================================================
  a_sys_rst_timing : assert property (
    @(posedge sys_clk) disable iff (!chk_en)
    sys_rst_n == (model_cnt == 0)
  ) else begin
    err_cnt++;
    $display("** Error: sys_rst_n = %h, expected %h", $sampled(sys_rst_n),
             $sampled(model_cnt == 0));
  end

  a_flags : assert property (
    @(posedge sys_clk) disable iff (!chk_en)
    rst_flags == model_flags
  ) else begin
    err_cnt++;
    $display("** Error: rst_flags = %h, expected %h", $sampled(rst_flags),
             $sampled(model_flags));
  end

  a_ker_low_in_reset : assert property (
    @(posedge sys_clk) disable iff (!chk_en || testmode)
    !sys_rst_n |-> (ker_rst_n == '0)
  ) else begin
    err_cnt++;
    $display("** Error: ker_rst_n = %h, expected 00", $sampled(ker_rst_n));
  end

  a_css_bound : assert property (
    @(posedge sys_clk) disable iff (!chk_en)
    (css_on && hse_idle >= CSS_TIMEOUT + 4) |-> hsecss_fail
  ) else begin
    err_cnt++;
    $display("** Error: hsecss_fail = %h, expected 1 after %0h idle cycles",
             $sampled(hsecss_fail), $sampled(hse_idle));
  end

  // a running oscillator must never be reported
  a_css_not_early : assert property (
    @(posedge sys_clk) disable iff (!chk_en)
    $rose(hsecss_fail) |-> (hse_idle >= CSS_TIMEOUT)
  ) else begin
    err_cnt++;
    $display("** Error: hsecss_fail = %h after %0h idle cycles, expected at least %0h",
             $sampled(hsecss_fail), $sampled(hse_idle), CSS_TIMEOUT);
  end

  a_css_off : assert property (
    @(posedge sys_clk) disable iff (!chk_en)
    !css_on |-> !hsecss_fail
  ) else begin
    err_cnt++;
    $display("** Error: hsecss_fail = %h, expected 0", $sampled(hsecss_fail));
  end

  a_fail_rst_release : assert property (
    @(posedge sys_clk) disable iff (!chk_en || testmode)
    sync_hsecss_fail_rst == (fail_low_cnt < STAGE_NUM)
  ) else begin
    err_cnt++;
    $display("** Error: sync_hsecss_fail_rst = %h, expected %h",
             $sampled(sync_hsecss_fail_rst), $sampled(fail_low_cnt < STAGE_NUM));
  end

  a_test_bypass : assert property (
    @(posedge sys_clk) disable iff (!chk_en)
    testmode |-> (ker_rst_n == {NUM_KER{test_rst_n}})
                 && (sync_hsecss_fail_rst == !test_rst_n)
  ) else begin
    err_cnt++;
    $display("** Error: ker_rst_n = %h, sync_hsecss_fail_rst = %h, test_rst_n = %h",
             $sampled(ker_rst_n), $sampled(sync_hsecss_fail_rst),
             $sampled(test_rst_n));
  end

  // ==========================================================
  // stimulus helpers
  // ==========================================================

  // inputs change 1 ns after the rising edge
  task automatic next_drive_slot();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic wait_sys_cycles(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge sys_clk);
    end
  endtask

  function automatic int rand_gap();
    return $urandom_range(12, 4);
  endfunction

  function automatic logic watched_value(input int sel);
    case (sel)
      W_SYS_RST: return sys_rst_n;
      W_FAIL:    return hsecss_fail;
      default:   return sync_hsecss_fail_rst;
    endcase
  endfunction

  task automatic pulse_strobe(input int sel);
    next_drive_slot();
    case (sel)
      STB_SW:     sw_rst_req  = 1'b1;
      STB_WDG:    wdg_rst_req = 1'b1;
      STB_RMVF:   rmvf        = 1'b1;
      STB_CSS_EN: css_en      = 1'b1;
      default:    css_clr     = 1'b1;
    endcase
    next_drive_slot();
    sw_rst_req  = 1'b0;
    wdg_rst_req = 1'b0;
    rmvf        = 1'b0;
    css_en      = 1'b0;
    css_clr     = 1'b0;
  endtask

  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what);
    int n;
    n = 0;
    while (watched_value(sel) !== level && n < limit) begin
      next_drive_slot();
      n++;
    end
    if (watched_value(sel) !== level) begin
      tmo_cnt++;
      $display("timeout after %0d cycles waiting for %s", limit, what);
    end
  endtask

  // ==========================================================
  // test sequence
  // ==========================================================
  initial begin : stimulus
    void'($urandom(27));
    rst_n       = 1'b0;
    sw_rst_req  = 1'b0;
    wdg_rst_req = 1'b0;
    rmvf        = 1'b0;
    css_en      = 1'b0;
    css_clr     = 1'b0;
    testmode    = 1'b0;
    test_rst_n  = 1'b1;
    hse_stop    = 1'b0;
    chk_en      = 1'b0;
    err_cnt     = 0;
    tmo_cnt     = 0;

    // power-on reset held for 16 cycles
    next_drive_slot();
    next_drive_slot();
    chk_en = 1'b1;
    wait_sys_cycles(14);
    #1;
    rst_n = 1'b1;
    wait_level(W_SYS_RST, 1'b1, RST_PULSE + 4, "power-on release");
    wait_sys_cycles(rand_gap());

    // stopped oscillator with monitoring still off
    next_drive_slot();
    hse_stop = 1'b1;
    wait_sys_cycles(CSS_TIMEOUT + 12);
    next_drive_slot();
    hse_stop = 1'b0;
    wait_sys_cycles(rand_gap());

    // software reset then watchdog with a restart mid stretch
    pulse_strobe(STB_SW);
    wait_level(W_SYS_RST, 1'b1, RST_PULSE + 4, "release after sw reset");
    pulse_strobe(STB_RMVF);
    wait_sys_cycles(rand_gap());
    pulse_strobe(STB_WDG);
    wait_sys_cycles(5);
    pulse_strobe(STB_SW);
    wait_level(W_SYS_RST, 1'b1, RST_PULSE + 4, "release after wdg and sw reset");
    wait_sys_cycles(rand_gap());
    pulse_strobe(STB_RMVF);

    // clock security failure and clear
    pulse_strobe(STB_CSS_EN);
    wait_sys_cycles(rand_gap());
    next_drive_slot();
    hse_stop = 1'b1;
    wait_level(W_FAIL, 1'b1, CSS_TIMEOUT + 8, "hsecss_fail after oscillator stop");
    wait_sys_cycles(rand_gap());
    next_drive_slot();
    hse_stop = 1'b0;
    wait_sys_cycles(8);
    pulse_strobe(STB_CSS_CLR);
    wait_level(W_SYNC_FAIL, 1'b0, STAGE_NUM + 4, "sync_hsecss_fail_rst release");
    wait_sys_cycles(rand_gap());
    pulse_strobe(STB_RMVF);

    // test mode bypass with an even toggle count so test_rst_n ends high
    next_drive_slot();
    testmode = 1'b1;
    for (int t = 0; t < 6; t++) begin
      wait_sys_cycles(rand_gap());
      next_drive_slot();
      test_rst_n = ~test_rst_n;
    end
    wait_sys_cycles(6);
    next_drive_slot();
    testmode = 1'b0;
    wait_sys_cycles(10);

    $display("rcc_rst_tb done: %0d check errors, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- rcc_rst_top.f
rcc_pkg.sv
rcc_reset_sync.sv
rcc_sys_rst_ctrl.sv
rcc_hse_css.sv
rcc_port_rst_sync.sv
rcc_rst_top.sv
rcc_rst_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run rcc_rst_tb with Verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal --top-module rcc_rst_tb \
  -f rcc_rst_top.f -o rcc_rst_sim > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/rcc_rst_sim > "$SIM_LOG" 2>&1 \
  || { cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$SIM_LOG"
grep -qx "Regression passed" "$SIM_LOG" && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
